//--- verilog/uart_cfg_pkg.sv
package uart_cfg_pkg;

   typedef logic [1:0]  cfg_addr_t;
   typedef logic [15:0] cfg_data_t;

   localparam cfg_addr_t addr_ctrl   = 2'd0;
   localparam cfg_addr_t addr_div    = 2'd1;
   localparam cfg_addr_t addr_status = 2'd2;
   localparam cfg_addr_t addr_data   = 2'd3;

   // divisor D gives one tick every D+1 clocks.
   localparam int div_w = 12;

   typedef logic [div_w-1:0] baud_div_t;

   localparam int ctrl_parity_en_bit  = 0;
   localparam int ctrl_parity_odd_bit = 1;

   typedef struct packed {
      logic      parity_en;
      logic      parity_odd;
      baud_div_t div;
   } uart_cfg_t;

endpackage

//--- verilog/uart_frame_pkg.sv
package uart_frame_pkg;

   localparam int word_w       = 8;
   localparam int oversampling = 16;
   // start edge to middle of start bit, in ticks.
   localparam int tick_mid     = oversampling / 2 - 1;

   typedef logic [3:0]        tick_cnt_t;
   typedef logic [3:0]        bit_cnt_t;
   typedef logic [word_w-1:0] uart_word_t;

   typedef struct packed {
      uart_word_t data;
      logic       parity_err;
      logic       frame_err;
   } rx_result_t;

   typedef enum logic [2:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_parity,
      rx_stop
   } rx_state_t;

   typedef enum logic [2:0] {
      tx_idle,
      tx_start,
      tx_data,
      tx_parity,
      tx_stop
   } tx_state_t;

endpackage

//--- verilog/uart_baud_gen.sv
`timescale 1ns/1ps

module uart_baud_gen (
   input  logic                   clk,
   input  logic                   rst_n,
   input  uart_cfg_pkg::uart_cfg_t cfg,
   output logic                   tick
);

   import uart_cfg_pkg::*;

   baud_div_t cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt  <= '0;
         tick <= 1'b0;
      end else begin
         if (cnt == '0) begin
            cnt  <= cfg.div; // new divisor picked up here.
            tick <= 1'b1;
         end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
         end
      end
   end

   // D must be at least 1.
   a_tick_single: assert property (
      @(posedge clk) disable iff (!rst_n) tick |=> !tick
   );

endmodule

//--- verilog/uart_rx_des.sv
`timescale 1ns/1ps

module uart_rx_des (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        tick,
   input  logic                        rxd,
   input  uart_cfg_pkg::uart_cfg_t     cfg,
   output logic                        rx_done,
   output uart_frame_pkg::rx_result_t  rx_result
);

   import uart_frame_pkg::*;

   logic [1:0] rxd_sync;
   logic       rxd_s;
   logic       sample;
   rx_state_t  state;
   tick_cnt_t  tick_cnt;
   bit_cnt_t   bit_cnt;
   logic       par_en_q;
   logic       par_odd_q;
   logic       par_acc;
   logic       par_err;
   uart_word_t shreg;

   assign rxd_s  = rxd_sync[1];
   assign sample = tick && (tick_cnt == '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rxd_sync  <= 2'b11; // line idles high.
         state     <= rx_idle;
         tick_cnt  <= '0;
         bit_cnt   <= '0;
         par_en_q  <= 1'b0;
         par_odd_q <= 1'b0;
         par_acc   <= 1'b0;
         par_err   <= 1'b0;
         rx_done   <= 1'b0;
      end else begin
         rxd_sync <= {rxd_sync[0], rxd};
         rx_done  <= 1'b0;
         if (tick && tick_cnt != '0)
            tick_cnt <= tick_cnt - 1'b1;
         case (state)
            rx_idle: begin
               if (!rxd_s) begin
                  state     <= rx_start;
                  tick_cnt  <= tick_cnt_t'(tick_mid);
                  bit_cnt   <= '0;
                  par_en_q  <= cfg.parity_en;
                  par_odd_q <= cfg.parity_odd;
                  par_acc   <= 1'b0;
                  par_err   <= 1'b0;
               end
            end
            rx_start: begin
               if (sample) begin
                  tick_cnt <= tick_cnt_t'(oversampling - 1);
                  state    <= rxd_s ? rx_idle : rx_data; // high here was a glitch.
               end
            end
            rx_data: begin
               if (sample) begin
                  tick_cnt <= tick_cnt_t'(oversampling - 1);
                  par_acc  <= par_acc ^ rxd_s;
                  if (bit_cnt == bit_cnt_t'(word_w - 1))
                     state <= par_en_q ? rx_parity : rx_stop;
                  else
                     bit_cnt <= bit_cnt + 1'b1;
               end
            end
            rx_parity: begin
               if (sample) begin
                  tick_cnt <= tick_cnt_t'(oversampling - 1);
                  par_err  <= (par_acc ^ rxd_s) != par_odd_q;
                  state    <= rx_stop;
               end
            end
            rx_stop: begin
               if (sample) begin
                  rx_done <= 1'b1;
                  state   <= rx_idle;
               end
            end
            default: state <= rx_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (sample && state == rx_data)
         shreg <= {rxd_s, shreg[word_w-1:1]}; // lsb arrives first.
      if (sample && state == rx_stop)
         rx_result <= '{data: shreg, parity_err: par_err, frame_err: ~rxd_s};
   end

   // a strobe only ever closes a frame with all data bits counted.
   a_done_after_stop: assert property (
      @(posedge clk) disable iff (!rst_n)
      rx_done |-> $past(state) == rx_stop && $past(bit_cnt) == bit_cnt_t'(word_w - 1)
   );

endmodule

//--- verilog/uart_tx_ser.sv
`timescale 1ns/1ps

module uart_tx_ser (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       tick,
   input  uart_cfg_pkg::uart_cfg_t    cfg,
   input  logic                       tx_start,
   input  uart_frame_pkg::uart_word_t tx_data,
   output logic                       txd,
   output logic                       tx_busy
);

   import uart_frame_pkg::*;

   tx_state_t  state;
   tick_cnt_t  tick_cnt;
   bit_cnt_t   bit_cnt;
   logic       bit_end;
   logic       par_en_q;
   logic       par_bit;
   uart_word_t shreg;

   assign bit_end = tick && (tick_cnt == '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= tx_idle;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         par_en_q <= 1'b0;
         txd      <= 1'b1;
         tx_busy  <= 1'b0;
      end else begin
         if (tick && tick_cnt != '0)
            tick_cnt <= tick_cnt - 1'b1;
         case (state)
            tx_idle: begin
               if (tx_start) begin
                  state    <= uart_frame_pkg::tx_start;
                  tick_cnt <= '0;
                  par_en_q <= cfg.parity_en;
                  tx_busy  <= 1'b1;
               end
            end
            uart_frame_pkg::tx_start: begin
               if (tick && txd) begin
                  txd      <= 1'b0; // first tick opens the start bit.
                  tick_cnt <= tick_cnt_t'(oversampling - 1);
               end else if (bit_end) begin
                  txd      <= shreg[0];
                  bit_cnt  <= '0;
                  tick_cnt <= tick_cnt_t'(oversampling - 1);
                  state    <= uart_frame_pkg::tx_data;
               end
            end
            uart_frame_pkg::tx_data: begin
               if (bit_end) begin
                  tick_cnt <= tick_cnt_t'(oversampling - 1);
                  if (bit_cnt == bit_cnt_t'(word_w - 1)) begin
                     txd   <= par_en_q ? par_bit : 1'b1;
                     state <= par_en_q ? tx_parity : tx_stop;
                  end else begin
                     txd     <= shreg[0];
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            tx_parity: begin
               if (bit_end) begin
                  txd      <= 1'b1;
                  tick_cnt <= tick_cnt_t'(oversampling - 1);
                  state    <= tx_stop;
               end
            end
            tx_stop: begin
               if (bit_end) begin
                  tx_busy <= 1'b0;
                  state   <= tx_idle;
               end
            end
            default: state <= tx_idle;
         endcase
      end
   end

   // the opening tick of the start bit keeps the word in place.
   always_ff @(posedge clk) begin
      if (state == tx_idle && tx_start) begin
         shreg   <= tx_data;
         par_bit <= ^tx_data ^ cfg.parity_odd; // even parity unless odd set.
      end else if (bit_end && ((state == uart_frame_pkg::tx_start && !txd) ||
                               state == uart_frame_pkg::tx_data)) begin
         shreg <= shreg >> 1;
      end
   end

   a_idle_line_high: assert property (
      @(posedge clk) disable iff (!rst_n) !tx_busy |-> txd
   );

endmodule

//--- verilog/uart_regs.sv
`timescale 1ns/1ps

module uart_regs (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       cfg_we,
   input  logic                       cfg_re,
   input  uart_cfg_pkg::cfg_addr_t    cfg_addr,
   input  uart_cfg_pkg::cfg_data_t    cfg_wdata,
   output uart_cfg_pkg::cfg_data_t    cfg_rdata,
   output uart_cfg_pkg::uart_cfg_t    cfg,
   input  logic                       rx_done,
   input  uart_frame_pkg::rx_result_t rx_result,
   input  logic                       tx_busy,
   output logic                       tx_start,
   output uart_frame_pkg::uart_word_t tx_data
);

   import uart_cfg_pkg::*;
   import uart_frame_pkg::*;

   logic       rx_full;
   logic       overrun;
   logic       frame_err;
   logic       parity_err;
   logic       data_rd;
   logic       tx_go;
   uart_word_t rx_word;

   assign data_rd = cfg_re && cfg_addr == addr_data;
   assign tx_go   = cfg_we && cfg_addr == addr_data && !tx_busy && !tx_start;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cfg        <= '{parity_en: 1'b0, parity_odd: 1'b0, div: baud_div_t'(1)};
         rx_full    <= 1'b0;
         overrun    <= 1'b0;
         frame_err  <= 1'b0;
         parity_err <= 1'b0;
         tx_start   <= 1'b0;
      end else begin
         tx_start <= tx_go;
         if (cfg_we && cfg_addr == addr_ctrl) begin
            cfg.parity_en  <= cfg_wdata[ctrl_parity_en_bit];
            cfg.parity_odd <= cfg_wdata[ctrl_parity_odd_bit];
         end
         if (cfg_we && cfg_addr == addr_div)
            cfg.div <= cfg_wdata[div_w-1:0];
         if (cfg_we && cfg_addr == addr_status) begin
            if (cfg_wdata[1]) overrun    <= 1'b0; // write 1 to clear.
            if (cfg_wdata[2]) frame_err  <= 1'b0;
            if (cfg_wdata[3]) parity_err <= 1'b0;
         end
         if (data_rd)
            rx_full <= 1'b0;
         if (rx_done) begin // new flags win over a clear.
            rx_full <= 1'b1;
            if (rx_full && !data_rd)
               overrun <= 1'b1;
            if (rx_result.frame_err)
               frame_err <= 1'b1;
            if (rx_result.parity_err)
               parity_err <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_done)
         rx_word <= rx_result.data; // newer word replaces unread one.
      if (tx_go)
         tx_data <= cfg_wdata[word_w-1:0];
   end

   always_comb begin
      cfg_rdata = '0;
      case (cfg_addr)
         addr_ctrl: begin
            cfg_rdata[ctrl_parity_en_bit]  = cfg.parity_en;
            cfg_rdata[ctrl_parity_odd_bit] = cfg.parity_odd;
         end
         addr_div:    cfg_rdata[div_w-1:0] = cfg.div;
         addr_status: cfg_rdata[4:0] = {tx_busy | tx_start, parity_err, frame_err,
                                        overrun, rx_full};
         default:     cfg_rdata[word_w-1:0] = rx_word;
      endcase
   end

   a_no_start_busy: assert property (
      @(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy
   );

endmodule

//--- verilog/uart_top.sv
`timescale 1ns/1ps

module uart_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    cfg_we,
   input  logic                    cfg_re,
   input  uart_cfg_pkg::cfg_addr_t cfg_addr,
   input  uart_cfg_pkg::cfg_data_t cfg_wdata,
   output uart_cfg_pkg::cfg_data_t cfg_rdata,
   input  logic                    rxd,
   output logic                    txd
);

   import uart_cfg_pkg::*;
   import uart_frame_pkg::*;

   uart_cfg_t  cfg;
   logic       tick;
   logic       rx_done;
   rx_result_t rx_result;
   logic       tx_busy;
   logic       tx_start;
   uart_word_t tx_data;

   uart_regs regs_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_we    (cfg_we),
      .cfg_re    (cfg_re),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .cfg       (cfg),
      .rx_done   (rx_done),
      .rx_result (rx_result),
      .tx_busy   (tx_busy),
      .tx_start  (tx_start),
      .tx_data   (tx_data)
   );

   uart_baud_gen baud_i (
      .clk   (clk),
      .rst_n (rst_n),
      .cfg   (cfg),
      .tick  (tick)
   );

   uart_rx_des rx_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .tick      (tick),
      .rxd       (rxd),
      .cfg       (cfg),
      .rx_done   (rx_done),
      .rx_result (rx_result)
   );

   uart_tx_ser tx_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .tick     (tick),
      .cfg      (cfg),
      .tx_start (tx_start),
      .tx_data  (tx_data),
      .txd      (txd),
      .tx_busy  (tx_busy)
   );

endmodule

//--- sim/uart_tb.sv
`timescale 1ns/1ps

module uart_tb;

   import uart_cfg_pkg::*;
   import uart_frame_pkg::*;

   logic        clk;
   logic        rst_n;
   logic        cfg_we;
   logic        cfg_re;
   cfg_addr_t   cfg_addr;
   cfg_data_t   cfg_wdata;
   cfg_data_t   cfg_rdata;
   logic        rxd;
   logic        txd;
   logic        rxd_drv;
   logic        loopback;
   baud_div_t   cur_div;
   logic        cur_par_en;
   logic        cur_par_odd;
   uart_word_t  tx_got;
   logic        tx_par;

   assign rxd = loopback ? txd : rxd_drv;

   uart_top uart_top_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_we    (cfg_we),
      .cfg_re    (cfg_re),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .rxd       (rxd),
      .txd       (txd)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input string name, input uart_word_t got, input uart_word_t exp);
      if (got !== exp)
         abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_status(input string name, input cfg_data_t got, input cfg_data_t exp);
      if (got !== exp)
         abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_line(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   // even parity sets the bit when the data has an odd number of ones.
   function automatic logic parity_of(input uart_word_t w, input logic odd);
      int ones;
      int i;
      ones = 0;
      for (i = 0; i < word_w; i++)
         ones += int'(w[i]);
      return (ones % 2 == 1) ? ~odd : odd;
   endfunction

   function automatic int bit_clocks();
      return oversampling * (int'(cur_div) + 1);
   endfunction

   task automatic bus_write(input cfg_addr_t addr, input cfg_data_t data);
      @(posedge clk);
      #1;
      cfg_we    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      @(posedge clk);
      #1;
      cfg_we = 1'b0;
   endtask

   task automatic bus_read(input cfg_addr_t addr, input logic re, output cfg_data_t data);
      @(posedge clk);
      #1;
      cfg_re   = re;
      cfg_addr = addr;
      #40;
      data = cfg_rdata; // sampled mid-cycle away from the edges.
      @(posedge clk);
      #1;
      cfg_re = 1'b0;
   endtask

   task automatic expect_status(input cfg_data_t exp);
      cfg_data_t st;
      bus_read(addr_status, 1'b0, st);
      check_status("status", st, exp);
   endtask

   task automatic read_word_expect(input uart_word_t exp);
      cfg_data_t d;
      bus_read(addr_data, 1'b1, d);
      check_word("rx data", d[word_w-1:0], exp);
      check_status("rx data upper bits", d >> word_w, '0);
   endtask

   task automatic set_config(input baud_div_t div, input logic par_en, input logic par_odd);
      cfg_data_t ctrl;
      ctrl = '0;
      ctrl[ctrl_parity_en_bit]  = par_en;
      ctrl[ctrl_parity_odd_bit] = par_odd;
      bus_write(addr_div, cfg_data_t'(div));
      bus_write(addr_ctrl, ctrl);
      cur_div     = div;
      cur_par_en  = par_en;
      cur_par_odd = par_odd;
   endtask

   task automatic wait_flag(input cfg_data_t mask, input cfg_data_t value, input string what);
      cfg_data_t st;
      int polls;
      polls = 0;
      bus_read(addr_status, 1'b0, st);
      while ((st & mask) != value) begin
         if (polls == 2000)
            abort_run({"timeout while waiting for ", what});
         bus_read(addr_status, 1'b0, st);
         polls++;
      end
   endtask

   task automatic send_serial(input uart_word_t w, input logic bad_par, input logic bad_stop);
      int n;
      int i;
      n = bit_clocks();
      @(posedge clk);
      #1;
      rxd_drv = 1'b0;
      repeat (n) @(posedge clk);
      for (i = 0; i < word_w; i++) begin
         #1;
         rxd_drv = w[i];
         repeat (n) @(posedge clk);
      end
      if (cur_par_en) begin
         #1;
         rxd_drv = parity_of(w, cur_par_odd) ^ bad_par;
         repeat (n) @(posedge clk);
      end
      #1;
      if (bad_stop) begin
         rxd_drv = 1'b0; // short low stop whose tail reads as a false start.
         repeat (n * 3 / 4) @(posedge clk);
         #1;
         rxd_drv = 1'b1;
         repeat (n - n * 3 / 4) @(posedge clk);
      end else begin
         rxd_drv = 1'b1;
         repeat (n) @(posedge clk);
      end
   endtask

   task automatic capture_serial();
      int n;
      int waited;
      int i;
      n      = bit_clocks();
      waited = 0;
      tx_got = '0;
      tx_par = 1'b0;
      while (txd) begin
         if (waited == 200)
            abort_run("timeout while waiting for a start bit on txd");
         @(posedge clk);
         #1;
         waited++;
      end
      repeat (n / 2) @(posedge clk);
      #1;
      check_line("txd start bit", txd, 1'b0);
      for (i = 0; i < word_w; i++) begin
         repeat (n) @(posedge clk);
         #1;
         tx_got[i] = txd;
      end
      if (cur_par_en) begin
         repeat (n) @(posedge clk);
         #1;
         tx_par = txd;
      end
      repeat (n) @(posedge clk);
      #1;
      check_line("txd stop bit", txd, 1'b1);
   endtask

   task automatic check_idle_line(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         check_line("txd", txd, 1'b1);
      end
   endtask

   task automatic receive_and_check(input uart_word_t w);
      send_serial(w, 1'b0, 1'b0);
      wait_flag(16'h0001, 16'h0001, "rx_full");
      expect_status(16'h0001);
      read_word_expect(w);
      expect_status(16'h0000);
   endtask

   task automatic test_reset();
      expect_status(16'h0000);
      check_idle_line(100);
   endtask

   task automatic test_rx_plain();
      set_config(baud_div_t'(1), 1'b0, 1'b0);
      repeat (8) receive_and_check(uart_word_t'($urandom));
   endtask

   task automatic test_rx_parity();
      uart_word_t w;
      set_config(baud_div_t'(1), 1'b1, 1'b0);
      receive_and_check(uart_word_t'($urandom));
      set_config(baud_div_t'(1), 1'b1, 1'b1);
      receive_and_check(uart_word_t'($urandom));
      w = uart_word_t'($urandom);
      send_serial(w, 1'b1, 1'b0);
      wait_flag(16'h0001, 16'h0001, "rx_full after bad parity");
      expect_status(16'h0009);
      read_word_expect(w);
      expect_status(16'h0008);
      bus_write(addr_status, 16'h0008);
      expect_status(16'h0000);
   endtask

   task automatic test_rx_errors();
      uart_word_t w;
      set_config(baud_div_t'(1), 1'b0, 1'b0);
      w = uart_word_t'($urandom);
      send_serial(w, 1'b0, 1'b1);
      wait_flag(16'h0001, 16'h0001, "rx_full after low stop bit");
      expect_status(16'h0005);
      read_word_expect(w);
      expect_status(16'h0004);
      bus_write(addr_status, 16'h0004);
      expect_status(16'h0000);
      w = uart_word_t'($urandom);
      send_serial(w, 1'b0, 1'b0);
      send_serial(~w, 1'b0, 1'b0); // second word lands on a full register.
      wait_flag(16'h0002, 16'h0002, "overrun");
      expect_status(16'h0003);
      read_word_expect(~w);
      expect_status(16'h0002);
      bus_write(addr_status, 16'h0002);
      expect_status(16'h0000);
   endtask

   task automatic test_tx();
      uart_word_t w;
      cfg_data_t  st;
      set_config(baud_div_t'(1), 1'b1, 1'b0);
      w = uart_word_t'($urandom);
      bus_write(addr_data, {8'h00, w});
      fork
         capture_serial();
         begin
            bus_read(addr_status, 1'b0, st);
            check_status("status tx_busy", st & 16'h0010, 16'h0010);
            bus_write(addr_data, {8'h00, ~w}); // dropped while the line is busy.
         end
      join
      check_word("txd data", tx_got, w);
      check_line("txd parity bit", tx_par, parity_of(w, 1'b0));
      wait_flag(16'h0010, 16'h0000, "tx_busy to clear");
      expect_status(16'h0000);
      check_idle_line(2 * bit_clocks());
   endtask

   task automatic test_loopback();
      uart_word_t w;
      set_config(baud_div_t'(3), 1'b1, 1'b1);
      loopback = 1'b1;
      repeat (6) begin
         w = uart_word_t'($urandom);
         bus_write(addr_data, {8'h00, w});
         wait_flag(16'h0011, 16'h0001, "loopback word");
         expect_status(16'h0001);
         read_word_expect(w);
      end
      expect_status(16'h0000);
      loopback = 1'b0;
   endtask

   initial begin
      rst_n       = 1'b0;
      cfg_we      = 1'b0;
      cfg_re      = 1'b0;
      cfg_addr    = '0;
      cfg_wdata   = '0;
      rxd_drv     = 1'b1;
      loopback    = 1'b0;
      cur_div     = baud_div_t'(1);
      cur_par_en  = 1'b0;
      cur_par_odd = 1'b0;
      void'($urandom(32'h95346a66));
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      test_reset();
      test_rx_plain();
      test_rx_parity();
      test_rx_errors();
      test_tx();
      test_loopback();
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

//--- project.f
verilog/uart_cfg_pkg.sv
verilog/uart_frame_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_rx_des.sv
verilog/uart_tx_ser.sv
verilog/uart_regs.sv
verilog/uart_top.sv
sim/uart_tb.sv

//--- Makefile
TOP := uart_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
